// File: common/busPkg.sv
package busPkg;

	typedef logic [31:0] addrT;
	typedef logic [31:0] dataT;
	// bit 0 enables data bits 7..0
	typedef logic [3:0] byteEnT;

	// address areas from bits 31..29
	typedef enum logic [2:0] {
		areaCached   = 3'b000,
		areaUncached = 3'b001,
		areaPurge    = 3'b010,
		areaUnused   = 3'b011,
		areaIo       = 3'b111
	} areaT;

	function automatic areaT areaOf(addrT addr);
		areaT area;
		case (addr[31:29])
			3'b000:  area = areaCached;
			3'b001:  area = areaUncached;
			3'b010:  area = areaPurge;
			3'b111:  area = areaIo;
			default: area = areaUnused;
		endcase
		return area;
	endfunction

	// control register, one byte on lane 1
	typedef logic [7:0] ccrT;

	localparam addrT ccrAddr = 32'hFFFF_FE92;
	localparam int ccrLane = 1;
	localparam int ccrCeBit = 0;
	localparam int ccrCpBit = 4;
	localparam ccrT ccrWriteMask = ccrT'((1 << ccrCeBit) | (1 << ccrCpBit));

endpackage

// File: common/cachePkg.sv
package cachePkg;

	// one-hot way select
	typedef logic [3:0] wayT;

	// pseudo-LRU state, one bit per way pair
	// bit set means the lower way of the pair was used more recently
	// pairs by bit: 5=(0,1) 4=(0,2) 3=(0,3) 2=(1,2) 1=(1,3) 0=(2,3)
	typedef logic [5:0] lruT;

	// word inside a line
	typedef logic [1:0] wordSelT;

	localparam int lineWords = 4;
	localparam int numWays = 4;

	// all-zero state points at way 0 as least recent
	localparam lruT lruClear = 6'b000000;

	localparam wayT wayFirst = 4'b0001;
	localparam wayT waySecond = 4'b0010;
	localparam wayT wayThird = 4'b0100;
	localparam wayT wayFourth = 4'b1000;

endpackage

// File: common/arrayIf.sv
`timescale 1ns/1ps

interface arrayIf import busPkg::*, cachePkg::*; ();
	addrT   lookupAddr;
	addrT   wrAddr;
	wayT    wrWay;
	dataT   wrData;
	byteEnT wrBe;
	logic   fill;
	logic   write;
	logic   touch;
	logic   linePurge;

	logic   hit;
	wayT    hitWay;
	wayT    tagWay;
	dataT   readData;
	wayT    victimWay;

	modport ctrl (
		output lookupAddr, wrAddr, wrWay, wrData, wrBe, fill, write, touch, linePurge,
		input  hit, hitWay, tagWay, readData, victimWay
	);

	modport array (
		input  lookupAddr, wrAddr, wrWay, wrData, wrBe, fill, write, touch, linePurge,
		output hit, hitWay, tagWay, readData, victimWay
	);
endinterface

// File: cacheArray/lruTracker.sv
`timescale 1ns/1ps

module lruTracker import cachePkg::*; #(
	parameter int setBits = 6
) (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic [setBits-1:0] lookupIndex,
	input  logic [setBits-1:0] touchIndex,
	input  wayT                touchWay,
	input  logic               touch,
	input  logic               purgeAll,
	output wayT                victimWay
);

	localparam int numSets = 1 << setBits;

	lruT lruBits [numSets];

	// way older than the other three
	function automatic wayT oldestWay(lruT l);
		wayT w;
		casez (l)
			6'b000???: w = wayFirst;
			6'b1??00?: w = waySecond;
			6'b?1?1?0: w = wayThird;
			6'b??1?11: w = wayFourth;
			default:   w = wayFirst;
		endcase
		return w;
	endfunction

	// make the given way the most recent of its three pairs
	function automatic lruT markUsed(wayT way, lruT l);
		lruT n;
		case (way)
			wayFirst:  n = {3'b111, l[2:0]};
			waySecond: n = {1'b0, l[4:3], 2'b11, l[0]};
			wayThird:  n = {l[5], 1'b0, l[3], 1'b0, l[1], 1'b1};
			wayFourth: n = {l[5:4], 1'b0, l[2], 2'b00};
			default:   n = l;
		endcase
		return n;
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < numSets; s++)
				lruBits[s] <= lruClear;
		end else if (purgeAll) begin
			for (int s = 0; s < numSets; s++)
				lruBits[s] <= lruClear;
		end else if (touch) begin
			lruBits[touchIndex] <= markUsed(touchWay, lruBits[touchIndex]);
		end
	end

	assign victimWay = oldestWay(lruBits[lookupIndex]);

endmodule

// File: cacheArray/cacheArray.sv
`timescale 1ns/1ps

module cacheArray import busPkg::*, cachePkg::*; #(
	parameter int setBits = 6
) (
	input  logic   CLK,
	input  logic   RST_N,
	input  logic   purgeAll,
	arrayIf.array  arr
);

	localparam int numSets = 1 << setBits;
	// areas take bits 31..29, offset takes 3..0
	localparam int tagBits = 25 - setBits;

	typedef logic [setBits-1:0] indexT;
	typedef logic [tagBits-1:0] tagT;

	tagT                tags [numWays][numSets];
	logic [numSets-1:0] valid [numWays];
	dataT               lineData [numWays][numSets][lineWords];

	indexT   lookIdx;
	tagT     lookTag;
	wordSelT lookWord;
	indexT   wrIdx;
	tagT     wrTag;
	wordSelT wrWord;
	wayT     tagMatch;
	wayT     hitMatch;
	dataT    rdMux;

	assign lookIdx = arr.lookupAddr[setBits+3:4];
	assign lookTag = arr.lookupAddr[28:setBits+4];
	assign lookWord = arr.lookupAddr[3:2];
	assign wrIdx = arr.wrAddr[setBits+3:4];
	assign wrTag = arr.wrAddr[28:setBits+4];
	assign wrWord = arr.wrAddr[3:2];

	// compare in all ways, hit ways are one-hot so an OR makes the mux
	always_comb begin
		rdMux = '0;
		for (int w = 0; w < numWays; w++) begin
			tagMatch[w] = tags[w][lookIdx] == lookTag;
			hitMatch[w] = tagMatch[w] && valid[w][lookIdx];
			if (hitMatch[w])
				rdMux = rdMux | lineData[w][lookIdx][lookWord];
		end
	end

	assign arr.hit = |hitMatch;
	assign arr.hitWay = hitMatch;
	assign arr.tagWay = tagMatch;
	assign arr.readData = rdMux;

	always_ff @(posedge CLK) begin
		for (int w = 0; w < numWays; w++) begin
			if (arr.fill && arr.wrWay[w]) begin
				lineData[w][wrIdx][wrWord] <= arr.wrData;
				tags[w][wrIdx] <= wrTag;
			end else if (arr.write && arr.wrWay[w]) begin
				for (int b = 0; b < 4; b++) begin
					if (arr.wrBe[b])
						lineData[w][wrIdx][wrWord][8*b +: 8] <= arr.wrData[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int w = 0; w < numWays; w++)
				valid[w] <= '0;
		end else if (purgeAll) begin
			for (int w = 0; w < numWays; w++)
				valid[w] <= '0;
		end else begin
			for (int w = 0; w < numWays; w++) begin
				if (arr.fill && arr.wrWay[w])
					valid[w][wrIdx] <= 1'b1;
				else if (arr.linePurge && arr.wrWay[w])
					valid[w][wrIdx] <= 1'b0;
			end
		end
	end

	lruTracker #(
		.setBits(setBits)
	) i_lruTracker (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.lookupIndex(lookIdx),
		.touchIndex (wrIdx),
		.touchWay   (arr.wrWay),
		.touch      (arr.touch),
		.purgeAll   (purgeAll),
		.victimWay  (arr.victimWay)
	);

endmodule

// File: design/ccrRegister.sv
`timescale 1ns/1ps

module ccrRegister import busPkg::*; (
	input  logic   CLK,
	input  logic   RST_N,
	input  logic   cpuReq,
	input  logic   cpuWr,
	input  addrT   cpuAddr,
	input  byteEnT cpuBe,
	input  dataT   cpuWdata,
	output logic   ccrSel,
	output logic   cacheEnable,
	output logic   purgeAll,
	output dataT   ccrData
);

	ccrT ccr;
	ccrT readBack;

	assign ccrSel = (cpuAddr == ccrAddr) && cpuBe[ccrLane];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ccr <= '0;
		end else begin
			// purge bit lives for one cycle
			if (ccr[ccrCpBit])
				ccr[ccrCpBit] <= 1'b0;
			if (cpuReq && cpuWr && ccrSel)
				ccr <= cpuWdata[8*ccrLane +: 8] & ccrWriteMask;
		end
	end

	assign cacheEnable = ccr[ccrCeBit];
	assign purgeAll = ccr[ccrCpBit];

	always_comb begin
		readBack = ccr;
		readBack[ccrCpBit] = 1'b0;
	end

	assign ccrData = {4{readBack}};

endmodule

// File: design/cacheController.sv
`timescale 1ns/1ps

module cacheController import busPkg::*, cachePkg::*; (
	input  logic   CLK,
	input  logic   RST_N,
	input  logic   cpuReq,
	input  logic   cpuWr,
	input  addrT   cpuAddr,
	input  dataT   cpuWdata,
	input  byteEnT cpuBe,
	output dataT   cpuRdata,
	output logic   cpuBusy,
	output addrT   memAddr,
	output dataT   memWdata,
	output byteEnT memBe,
	output logic   memWe,
	output logic   memReq,
	output logic   memLock,
	input  logic   memWait,
	input  dataT   memRdata,
	input  logic   ccrSel,
	input  logic   cacheEnable,
	input  dataT   ccrData,
	arrayIf.ctrl   arr
);

	typedef enum logic [2:0] {idle, memWrite, memRead, readDone, lineFill} stateT;

	stateT   state;
	areaT    area;
	logic    accept;
	logic    cachedOn;
	logic    readHit;
	logic    readMiss;
	logic    passRead;
	logic    busWrite;
	logic    hitWrite;
	logic    purgeWrite;
	logic    fillStrobe;
	wordSelT critWord;
	wayT     fillWay;
	dataT    rdLatch;

	// new request, register accesses never leave idle
	assign area = areaOf(cpuAddr);
	assign accept = cpuReq && !ccrSel && (state == idle);
	assign cachedOn = (area == areaCached) && cacheEnable;

	assign readHit = accept && !cpuWr && cachedOn && arr.hit;
	assign readMiss = accept && !cpuWr && cachedOn && !arr.hit;
	assign passRead = accept && !cpuWr && !cachedOn
		&& (area inside {areaCached, areaUncached, areaIo});
	assign busWrite = accept && cpuWr && (area inside {areaCached, areaUncached, areaIo});
	assign hitWrite = busWrite && cachedOn && arr.hit;
	assign purgeWrite = accept && cpuWr && (area == areaPurge);
	assign fillStrobe = (state == lineFill) && !memWait;

	assign arr.lookupAddr = cpuAddr;
	assign arr.wrAddr = (state == lineFill) ? memAddr : cpuAddr;
	assign arr.wrWay = (state == lineFill) ? fillWay : purgeWrite ? arr.tagWay : arr.hitWay;
	assign arr.wrData = (state == lineFill) ? memRdata : cpuWdata;
	assign arr.wrBe = cpuBe;
	assign arr.fill = fillStrobe;
	assign arr.write = hitWrite;
	assign arr.touch = readHit || hitWrite || fillStrobe;
	assign arr.linePurge = purgeWrite;

	always_comb begin
		case (state)
			idle:     cpuBusy = readMiss || passRead || busWrite;
			memWrite: cpuBusy = cpuReq && memWait;
			memRead:  cpuBusy = cpuReq;
			lineFill: cpuBusy = cpuReq;
			default:  cpuBusy = 1'b0;
		endcase
	end

	always_comb begin
		if (ccrSel)
			cpuRdata = ccrData;
		else if (state == readDone)
			cpuRdata = rdLatch;
		else if (readHit)
			cpuRdata = arr.readData;
		else
			cpuRdata = '0;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= idle;
			memAddr <= '0;
			memWdata <= '0;
			memBe <= '0;
			memWe <= 1'b0;
			memReq <= 1'b0;
			memLock <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (busWrite) begin
						memAddr <= cpuAddr;
						memWdata <= cpuWdata;
						memBe <= cpuBe;
						memWe <= 1'b1;
						memReq <= 1'b1;
						state <= memWrite;
					end else if (passRead) begin
						memAddr <= cpuAddr;
						memBe <= cpuBe;
						memWe <= 1'b0;
						memReq <= 1'b1;
						state <= memRead;
					end else if (readMiss) begin
						// wrap order, requested word comes last
						memAddr <= {cpuAddr[31:4], cpuAddr[3:2] + 2'd1, 2'b00};
						memBe <= 4'b1111;
						memWe <= 1'b0;
						memReq <= 1'b1;
						memLock <= 1'b1;
						state <= lineFill;
					end
				end
				memWrite: begin
					if (!memWait) begin
						memReq <= 1'b0;
						memWe <= 1'b0;
						state <= idle;
					end
				end
				memRead: begin
					if (!memWait) begin
						memReq <= 1'b0;
						state <= readDone;
					end
				end
				readDone: state <= idle;
				lineFill: begin
					if (!memWait) begin
						memAddr[3:2] <= memAddr[3:2] + 2'd1;
						// unlock for the last word
						if (memAddr[3:2] == wordSelT'(critWord - 2'd1))
							memLock <= 1'b0;
						if (memAddr[3:2] == critWord) begin
							memReq <= 1'b0;
							state <= idle;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (readMiss) begin
			critWord <= cpuAddr[3:2];
			fillWay <= arr.victimWay;
		end
		if (state == memRead && !memWait)
			rdLatch <= memRdata;
	end

endmodule

// File: design/cacheTop.sv
`timescale 1ns/1ps

module cacheTop import busPkg::*; #(
	parameter int setBits = 6
) (
	input  logic   CLK,
	input  logic   RST_N,
	input  logic   cpuReq,
	input  logic   cpuWr,
	input  addrT   cpuAddr,
	input  dataT   cpuWdata,
	input  byteEnT cpuBe,
	output dataT   cpuRdata,
	output logic   cpuBusy,
	output addrT   memAddr,
	output dataT   memWdata,
	output byteEnT memBe,
	output logic   memWe,
	output logic   memReq,
	output logic   memLock,
	input  logic   memWait,
	input  dataT   memRdata
);

	logic ccrSel;
	logic cacheEnable;
	logic purgeAll;
	dataT ccrData;

	arrayIf arrBus ();

	cacheController i_cacheController (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.cpuReq     (cpuReq),
		.cpuWr      (cpuWr),
		.cpuAddr    (cpuAddr),
		.cpuWdata   (cpuWdata),
		.cpuBe      (cpuBe),
		.cpuRdata   (cpuRdata),
		.cpuBusy    (cpuBusy),
		.memAddr    (memAddr),
		.memWdata   (memWdata),
		.memBe      (memBe),
		.memWe      (memWe),
		.memReq     (memReq),
		.memLock    (memLock),
		.memWait    (memWait),
		.memRdata   (memRdata),
		.ccrSel     (ccrSel),
		.cacheEnable(cacheEnable),
		.ccrData    (ccrData),
		.arr        (arrBus.ctrl)
	);

	ccrRegister i_ccrRegister (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.cpuReq     (cpuReq),
		.cpuWr      (cpuWr),
		.cpuAddr    (cpuAddr),
		.cpuBe      (cpuBe),
		.cpuWdata   (cpuWdata),
		.ccrSel     (ccrSel),
		.cacheEnable(cacheEnable),
		.purgeAll   (purgeAll),
		.ccrData    (ccrData)
	);

	cacheArray #(
		.setBits(setBits)
	) i_cacheArray (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.purgeAll(purgeAll),
		.arr     (arrBus.array)
	);

endmodule

// File: bench/cacheChecker.sv
`timescale 1ns/1ps

module cacheChecker import busPkg::*; (
	input  logic   CLK,
	input  logic   RST_N,
	input  logic   cpuReq,
	input  logic   cpuBusy,
	input  logic   memReq,
	input  logic   memLock,
	input  logic   memWait,
	input  logic   memWe,
	input  addrT   memAddr,
	input  dataT   memWdata,
	input  byteEnT memBe
);

	// request fields frozen while the memory stalls
	property memHeld;
		@(posedge CLK) disable iff (!RST_N)
		memReq && memWait |=> memReq && $stable(memAddr) && $stable(memWdata)
			&& $stable(memBe) && $stable(memWe);
	endproperty

	property lockNeedsReq;
		@(posedge CLK) disable iff (!RST_N)
		memLock |-> memReq;
	endproperty

	property busyNeedsReq;
		@(posedge CLK) disable iff (!RST_N)
		cpuBusy |-> cpuReq;
	endproperty

	assert property (memHeld)
		else $error("memory request changed while memWait was high");
	assert property (lockNeedsReq)
		else $error("memLock high without memReq");
	assert property (busyNeedsReq)
		else $error("cpuBusy high without cpuReq");

endmodule

bind cacheTop cacheChecker i_cacheChecker (
	.CLK     (CLK),
	.RST_N   (RST_N),
	.cpuReq  (cpuReq),
	.cpuBusy (cpuBusy),
	.memReq  (memReq),
	.memLock (memLock),
	.memWait (memWait),
	.memWe   (memWe),
	.memAddr (memAddr),
	.memWdata(memWdata),
	.memBe   (memBe)
);

// File: bench/cacheTb.sv
`timescale 1ns/1ps

module cacheTb import busPkg::*, cachePkg::*; ();

	localparam int timeoutCycles = 40;

	typedef struct packed {
		logic   isWrite;
		addrT   addr;
		dataT   data;
		byteEnT be;
		dataT   expData;
		dataT   xfers;
	} rowT;

	logic   CLK = 1'b0;
	logic   RST_N;
	logic   cpuReq;
	logic   cpuWr;
	addrT   cpuAddr;
	dataT   cpuWdata;
	byteEnT cpuBe;
	dataT   cpuRdata;
	logic   cpuBusy;
	addrT   memAddr;
	dataT   memWdata;
	byteEnT memBe;
	logic   memWe;
	logic   memReq;
	logic   memLock;
	logic   memWait;
	dataT   memRdata;

	rowT  rows[$];
	dataT memWords [addrT];
	addrT curAddr;
	logic curWrite;
	int   xferCount;
	int   fillPos;

	always #5 CLK = ~CLK;

	cacheTop #(
		.setBits(6)
	) i_cacheTop (
		.CLK(CLK), .RST_N(RST_N),
		.cpuReq(cpuReq), .cpuWr(cpuWr), .cpuAddr(cpuAddr), .cpuWdata(cpuWdata),
		.cpuBe(cpuBe), .cpuRdata(cpuRdata), .cpuBusy(cpuBusy),
		.memAddr(memAddr), .memWdata(memWdata), .memBe(memBe), .memWe(memWe),
		.memReq(memReq), .memLock(memLock), .memWait(memWait), .memRdata(memRdata)
	);

	task automatic checkValue(input string name, input dataT got, input dataT exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Something failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// contents of a word that was never written
	function automatic dataT modelWord(addrT a);
		return a ^ 32'h5A5A_5A5A;
	endfunction

	function automatic dataT mergeBytes(dataT old, dataT nw, byteEnT be);
		dataT m;
		m = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				m[8*b +: 8] = nw[8*b +: 8];
		end
		return m;
	endfunction

	function automatic dataT readWord(addrT a);
		addrT key;
		key = {a[31:2], 2'b00};
		if (memWords.exists(key))
			return memWords[key];
		return modelWord(key);
	endfunction

	function automatic void addRow(logic wr, addrT a, dataT d, byteEnT be, dataT expD, dataT n);
		rowT r;
		r.isWrite = wr;
		r.addr = a;
		r.data = d;
		r.be = be;
		r.expData = expD;
		r.xfers = n;
		rows.push_back(r);
	endfunction

	task automatic completeTransfer();
		addrT fillAddr;
		if (fillPos > 0 || memLock) begin
			// line fill runs in wrap order with the requested word last
			fillAddr = {curAddr[31:4], wordSelT'(curAddr[3:2] + 1 + fillPos), 2'b00};
			checkValue("memAddr", memAddr, fillAddr);
			checkValue("memLock", 32'(memLock), 32'(fillPos < 3));
			fillPos = (fillPos == 3) ? 0 : fillPos + 1;
		end else begin
			checkValue("memAddr", memAddr, curAddr);
		end
		checkValue("memWe", 32'(memWe), 32'(curWrite));
		if (memWe)
			memWords[{memAddr[31:2], 2'b00}] = mergeBytes(readWord(memAddr), memWdata, memBe);
		xferCount++;
	endtask

	// memory model answering on the falling edge
	initial begin
		int waitLeft;
		logic fresh;
		memWait = 1'b0;
		memRdata = '0;
		fresh = 1'b1;
		waitLeft = 0;
		fillPos = 0;
		forever begin
			@(negedge CLK);
			if (memReq) begin
				if (fresh) begin
					waitLeft = int'($urandom % 4);
					fresh = 1'b0;
				end
				if (waitLeft > 0) begin
					memWait = 1'b1;
					waitLeft--;
				end else begin
					memWait = 1'b0;
					memRdata = readWord(memAddr);
				end
			end else begin
				memWait = 1'b0;
				fresh = 1'b1;
			end
			#4;
			if (memReq && !memWait) begin
				completeTransfer();
				fresh = 1'b1;
			end
		end
	end

	task automatic buildTable();
		dataT merged;
		merged = mergeBytes(modelWord(32'h0000_0128), 32'hA1B2_C3D4, 4'b0101);
		// pass-through reads while the cache is off
		addRow(1'b0, 32'h2000_0104, 32'h0, 4'hF, modelWord(32'h2000_0104), 32'd1);
		addRow(1'b0, 32'hE000_0208, 32'h0, 4'hF, modelWord(32'hE000_0208), 32'd1);
		addRow(1'b0, 32'h0000_0310, 32'h0, 4'hF, modelWord(32'h0000_0310), 32'd1);
		// enable then miss and hits in one line
		addRow(1'b1, ccrAddr, 32'h0000_0100, 4'b0010, 32'h0, 32'd0);
		addRow(1'b0, 32'h0000_0124, 32'h0, 4'hF, modelWord(32'h0000_0124), 32'd4);
		addRow(1'b0, 32'h0000_012C, 32'h0, 4'hF, modelWord(32'h0000_012C), 32'd0);
		addRow(1'b0, 32'h0000_0120, 32'h0, 4'hF, modelWord(32'h0000_0120), 32'd0);
		addRow(1'b1, 32'h0000_0128, 32'hA1B2_C3D4, 4'b0101, 32'h0, 32'd1);
		addRow(1'b0, 32'h0000_0128, 32'h0, 4'hF, merged, 32'd0);
		// line purge
		addRow(1'b1, 32'h4000_0120, 32'h0, 4'hF, 32'h0, 32'd0);
		addRow(1'b0, 32'h0000_0124, 32'h0, 4'hF, modelWord(32'h0000_0124), 32'd4);
		addRow(1'b0, 32'h0000_0128, 32'h0, 4'hF, merged, 32'd0);
		// five tags into set 5
		for (int t = 0; t < 5; t++)
			addRow(1'b0, addrT'(32'h50 + t * 32'h400), 32'h0, 4'hF,
				modelWord(addrT'(32'h50 + t * 32'h400)), 32'd4);
		// the four newer tags still hit
		for (int t = 1; t < 5; t++)
			addRow(1'b0, addrT'(32'h50 + t * 32'h400), 32'h0, 4'hF,
				modelWord(addrT'(32'h50 + t * 32'h400)), 32'd0);
		addRow(1'b0, 32'h0000_0050, 32'h0, 4'hF, modelWord(32'h0000_0050), 32'd4);
		// purge-all then register read-back
		addRow(1'b1, ccrAddr, 32'h0000_1100, 4'b0010, 32'h0, 32'd0);
		addRow(1'b0, ccrAddr, 32'h0, 4'b0010, 32'h0101_0101, 32'd0);
		addRow(1'b0, 32'h0000_012C, 32'h0, 4'hF, modelWord(32'h0000_012C), 32'd4);
		addRow(1'b0, 32'h0000_1050, 32'h0, 4'hF, modelWord(32'h0000_1050), 32'd4);
	endtask

	task automatic applyRow(input rowT r, input int idx);
		int cycles;
		logic done;
		dataT got;
		cpuReq = 1'b1;
		cpuWr = r.isWrite;
		cpuAddr = r.addr;
		cpuWdata = r.data;
		cpuBe = r.be;
		curAddr = r.addr;
		curWrite = r.isWrite;
		xferCount = 0;
		cycles = 0;
		done = 1'b0;
		got = '0;
		while (!done) begin
			// sample one ns before the rising edge
			#4;
			if (!cpuBusy) begin
				done = 1'b1;
				got = cpuRdata;
			end
			@(posedge CLK);
			@(negedge CLK);
			cycles++;
			if (!done && cycles > timeoutCycles) begin
				$display("timeout: cpuBusy stayed high for %0d cycles on row %0d", cycles, idx);
				$display("Something failed");
				$fatal(1, "request never completed");
			end
		end
		cpuReq = 1'b0;
		cpuWr = 1'b0;
		if (!r.isWrite)
			checkValue("cpuRdata", got, r.expData);
		checkValue("memory transfers", dataT'(xferCount), r.xfers);
		@(negedge CLK);
	endtask

	initial begin
		void'($urandom(32'hbbce_91df));
		RST_N = 1'b0;
		cpuReq = 1'b0;
		cpuWr = 1'b0;
		cpuAddr = '0;
		cpuWdata = '0;
		cpuBe = '0;
		curAddr = '0;
		curWrite = 1'b0;
		xferCount = 0;
		buildTable();
		repeat (8) @(negedge CLK);
		RST_N = 1'b1;
		@(negedge CLK);
		foreach (rows[i])
			applyRow(rows[i], i);
		$display("Everything OK");
		$finish;
	end

endmodule

// File: src.f
common/busPkg.sv
common/cachePkg.sv
common/arrayIf.sv
cacheArray/lruTracker.sv
cacheArray/cacheArray.sv
design/ccrRegister.sv
design/cacheController.sv
design/cacheTop.sv
bench/cacheChecker.sv
bench/cacheTb.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cacheTb -f src.f -o cacheTbSim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/cacheTbSim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

exit 0
